/* rtl/lsu_isa_pkg.sv */
// load/store op encodings and the request and response
// seen at the pipeline boundary
package lsu_isa_pkg;

  // data and address width
  localparam int XLEN = 32;

  // width of each op field
  localparam int OP_W = 3;

  // load ops, zero means no load
  localparam logic [OP_W-1:0] LD_NONE = 3'd0;
  localparam logic [OP_W-1:0] LD_LB   = 3'd1;
  localparam logic [OP_W-1:0] LD_LH   = 3'd2;
  localparam logic [OP_W-1:0] LD_LW   = 3'd3;
  localparam logic [OP_W-1:0] LD_LBU  = 3'd4;
  localparam logic [OP_W-1:0] LD_LHU  = 3'd5;

  // store ops, zero means no store
  localparam logic [OP_W-1:0] ST_NONE = 3'd0;
  localparam logic [OP_W-1:0] ST_SB   = 3'd1;
  localparam logic [OP_W-1:0] ST_SH   = 3'd2;
  localparam logic [OP_W-1:0] ST_SW   = 3'd3;

  // request from the execute stage, 70 bits
  // at most one of load_op and store_op is nonzero
  typedef struct packed {
    logic [OP_W-1:0] load_op;
    logic [OP_W-1:0] store_op;
    // effective address, alu result
    logic [XLEN-1:0] addr;
    // store source operand, rs2
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  // response toward writeback, 34 bits
  typedef struct packed {
    // extended load data, zero for stores and misaligned
    logic [XLEN-1:0] data;
    // alignment fault flag only, no trap raised here
    logic            misaligned;
    logic            is_store;
  } lsu_rsp_t;

endpackage

/* rtl/lsu_mem_pkg.sv */
// geometry of the on-chip data sram and its port
package lsu_mem_pkg;

  // depth in words, 4 KiB total
  localparam int MEM_WORDS = 1024;

  // word index width, taken from addr[11:2]
  localparam int MEM_AW = 10;

  // byte lanes per word
  localparam int LANES = 4;

  localparam int BYTE_W = 8;
  localparam int HALF_W = 16;

  // one sram word
  // byte view for lb/lbu and sb
  // halfword view for lh/lhu and sh
  typedef union packed {
    logic [LANES-1:0][BYTE_W-1:0]   b;
    logic [LANES/2-1:0][HALF_W-1:0] h;
  } mem_word_u;

  // single port request, 48 bits
  typedef struct packed {
    // access this cycle
    logic              en;
    // write when set, else read
    logic              we;
    logic [MEM_AW-1:0] index;
    // per-lane write strobe
    logic [LANES-1:0]  be;
    mem_word_u         wdata;
  } sram_req_t;

endpackage

/* rtl/lsu_store_align.sv */
`timescale 1ns/1ps

// store data lane steering
// purely combinational
module lsu_store_align (
  input  logic [lsu_isa_pkg::OP_W-1:0]   i_store_op,
  input  logic [1:0]                     i_addr_lo,
  input  logic [lsu_isa_pkg::XLEN-1:0]   i_wdata,
  output logic [lsu_mem_pkg::LANES-1:0]  o_be,
  output lsu_mem_pkg::mem_word_u         o_wdata
);

  // low parts of the source operand
  logic [lsu_mem_pkg::BYTE_W-1:0] src_byte;
  logic [lsu_mem_pkg::HALF_W-1:0] src_half;

  assign src_byte = i_wdata[lsu_mem_pkg::BYTE_W-1:0];
  assign src_half = i_wdata[lsu_mem_pkg::HALF_W-1:0];

  always_comb begin
    // no strobe unless a store op is present
    o_be    = '0;
    o_wdata = '0;
    case (i_store_op)
      lsu_isa_pkg::ST_SB: begin
        // byte copied to every lane
        // strobe picks the one addressed
        for (int l = 0; l < lsu_mem_pkg::LANES; l++) begin
          o_wdata.b[l] = src_byte;
        end
        o_be[i_addr_lo] = 1'b1;
      end
      lsu_isa_pkg::ST_SH: begin
        // halfword in both halves
        for (int h = 0; h < lsu_mem_pkg::LANES / 2; h++) begin
          o_wdata.h[h] = src_half;
        end
        // bit 1 selects the upper pair of lanes
        if (i_addr_lo[1]) begin
          o_be = 4'b1100;
        end else begin
          o_be = 4'b0011;
        end
      end
      lsu_isa_pkg::ST_SW: begin
        // whole word, all lanes
        o_wdata = i_wdata;
        o_be    = '1;
      end
      default: begin
        // ST_NONE and unused codes
        o_be    = '0;
        o_wdata = '0;
      end
    endcase
  end

endmodule

/* rtl/lsu_data_sram.sv */
`timescale 1ns/1ps

// word-wide data sram
// one port, byte strobed write, registered read
module lsu_data_sram (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  lsu_mem_pkg::sram_req_t  i_req,
  output lsu_mem_pkg::mem_word_u  o_rdata,
  output logic                    o_rd_valid
);

  // storage, contents not reset
  lsu_mem_pkg::mem_word_u mem [lsu_mem_pkg::MEM_WORDS];

  // decoded port commands
  logic wr_go;
  logic rd_go;

  assign wr_go = i_req.en & i_req.we;
  assign rd_go = i_req.en & ~i_req.we;

  // write path
  // only strobed lanes change, others keep old bytes
  always_ff @(posedge i_clk) begin
    if (wr_go) begin
      for (int l = 0; l < lsu_mem_pkg::LANES; l++) begin
        if (i_req.be[l]) begin
          mem[i_req.index].b[l] <= i_req.wdata.b[l];
        end
      end
    end
  end

  // read path
  // word held until the next read
  // a load one cycle after a store sees the committed write
  always_ff @(posedge i_clk) begin
    if (rd_go) begin
      o_rdata <= mem[i_req.index];
    end
  end

  // read return strobe
  // high in the cycle o_rdata holds fresh data
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= rd_go;
    end
  end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

// load/store unit
// stage 1 is the sram edge, stage 2 the load extension
// fixed two cycle latency, no stall
module lsu (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_pre_valid,
  input  lsu_isa_pkg::lsu_req_t   i_req,
  input  lsu_mem_pkg::mem_word_u  i_rdata,
  output lsu_mem_pkg::sram_req_t  o_sram_req,
  output logic                    o_post_valid,
  output lsu_isa_pkg::lsu_rsp_t   o_rsp
);

  // state carried alongside the sram access
  typedef struct packed {
    logic                         valid;
    logic [lsu_isa_pkg::OP_W-1:0] load_op;
    logic [1:0]                   addr_lo;
    logic                         misaligned;
    logic                         is_store;
  } s1_t;

  logic                                is_load;
  logic                                is_store;
  logic                                need_half;
  logic                                need_word;
  logic                                misaligned;
  logic                                mem_go;
  logic [lsu_mem_pkg::LANES-1:0]       st_be;
  lsu_mem_pkg::mem_word_u              st_wdata;
  s1_t                                 s1_q;
  logic [lsu_mem_pkg::BYTE_W-1:0]      ld_byte;
  logic [lsu_mem_pkg::HALF_W-1:0]      ld_half;
  logic [lsu_isa_pkg::XLEN-1:0]        ld_ext;

  assign is_load  = |i_req.load_op;
  assign is_store = |i_req.store_op;

  // natural alignment
  // halfword needs bit 0 clear, word needs bits 1..0 clear
  assign need_half = (i_req.load_op == lsu_isa_pkg::LD_LH) |
                     (i_req.load_op == lsu_isa_pkg::LD_LHU) |
                     (i_req.store_op == lsu_isa_pkg::ST_SH);
  assign need_word = (i_req.load_op == lsu_isa_pkg::LD_LW) |
                     (i_req.store_op == lsu_isa_pkg::ST_SW);
  assign misaligned = (need_half & i_req.addr[0]) | (need_word & (|i_req.addr[1:0]));

  // misaligned requests never touch the sram
  assign mem_go = i_pre_valid & (is_load | is_store) & ~misaligned;

  lsu_store_align store_align_inst (
    .i_store_op (i_req.store_op),
    .i_addr_lo  (i_req.addr[1:0]),
    .i_wdata    (i_req.wdata),
    .o_be       (st_be),
    .o_wdata    (st_wdata)
  );

  // sram request, upper address bits dropped
  always_comb begin
    o_sram_req.en    = mem_go;
    o_sram_req.we    = mem_go & is_store;
    o_sram_req.index = i_req.addr[lsu_mem_pkg::MEM_AW+1:2];
    o_sram_req.be    = st_be;
    o_sram_req.wdata = st_wdata;
  end

  // stage 1, in step with the sram read register
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_q <= '0;
    end else begin
      s1_q.valid      <= i_pre_valid;
      s1_q.load_op    <= i_req.load_op;
      s1_q.addr_lo    <= i_req.addr[1:0];
      s1_q.misaligned <= misaligned;
      s1_q.is_store   <= is_store;
    end
  end

  // lane select through the union views
  assign ld_byte = i_rdata.b[s1_q.addr_lo];
  assign ld_half = i_rdata.h[s1_q.addr_lo[1]];

  always_comb begin
    case (s1_q.load_op)
      lsu_isa_pkg::LD_LB:  ld_ext = {{(lsu_isa_pkg::XLEN-8){ld_byte[7]}}, ld_byte};
      lsu_isa_pkg::LD_LH:  ld_ext = {{(lsu_isa_pkg::XLEN-16){ld_half[15]}}, ld_half};
      lsu_isa_pkg::LD_LW:  ld_ext = i_rdata;
      lsu_isa_pkg::LD_LBU: ld_ext = {{(lsu_isa_pkg::XLEN-8){1'b0}}, ld_byte};
      lsu_isa_pkg::LD_LHU: ld_ext = {{(lsu_isa_pkg::XLEN-16){1'b0}}, ld_half};
      default:             ld_ext = '0;
    endcase
    // stores and faults return zero data
    if (s1_q.misaligned || s1_q.is_store) begin
      ld_ext = '0;
    end
  end

  // stage 2, response register
  // holds the last response between strobes
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_post_valid <= 1'b0;
      o_rsp        <= '0;
    end else begin
      o_post_valid <= s1_q.valid;
      if (s1_q.valid) begin
        o_rsp.data       <= ld_ext;
        o_rsp.misaligned <= s1_q.misaligned;
        o_rsp.is_store   <= s1_q.is_store;
      end
    end
  end

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps

// load/store unit with its data sram
// instances and wires only
module lsu_top (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_pre_valid,
  input  lsu_isa_pkg::lsu_req_t  i_req,
  output logic                   o_post_valid,
  output lsu_isa_pkg::lsu_rsp_t  o_rsp
);

  // lsu to sram
  lsu_mem_pkg::sram_req_t  sram_req;

  // sram to lsu
  lsu_mem_pkg::mem_word_u  sram_rdata;

  // read return strobe
  // lsu tracks validity itself, kept here for bound checks
  logic                    sram_rd_valid;

  lsu lsu_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pre_valid  (i_pre_valid),
    .i_req        (i_req),
    .i_rdata      (sram_rdata),
    .o_sram_req   (sram_req),
    .o_post_valid (o_post_valid),
    .o_rsp        (o_rsp)
  );

  // 4 KiB of data memory
  lsu_data_sram sram_inst (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_req      (sram_req),
    .o_rdata    (sram_rdata),
    .o_rd_valid (sram_rd_valid)
  );

endmodule

/* tb/lsu_top_assert.sv */
`timescale 1ns/1ps

// protocol checks on the load/store unit boundary
module lsu_top_assert (
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  i_pre_valid,
  input lsu_isa_pkg::lsu_req_t i_req,
  input logic                  i_sram_rd_valid,
  input logic                  i_post_valid,
  input lsu_isa_pkg::lsu_rsp_t i_rsp
);

  // count of failed assertions
  int err_count = 0;

  // a request is a load or a store, never both
  a_one_op : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pre_valid |-> ((i_req.load_op == '0) || (i_req.store_op == '0)))
    else begin
      $error("request carries both a load op and a store op");
      err_count++;
    end

  // fixed two cycle latency, one strobe per request
  a_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_post_valid == $past(i_pre_valid, 2))
    else begin
      $error("response strobe not two cycles after request strobe");
      err_count++;
    end

  // sram read data only comes back for a load issued one cycle earlier
  a_rd_return : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_sram_rd_valid |-> $past(i_pre_valid && (i_req.load_op != '0)))
    else begin
      $error("sram read returned without a load request");
      err_count++;
    end

  // quiet while reset is held
  a_reset_quiet : assert property (@(posedge i_clk)
    !i_rst_n |-> !i_post_valid)
    else begin
      $error("response strobe high during reset");
      err_count++;
    end

  // a faulting access returns no data
  a_mis_zero : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_post_valid && i_rsp.misaligned) |-> (i_rsp.data == '0))
    else begin
      $error("misaligned response with nonzero data");
      err_count++;
    end

endmodule

bind lsu_top lsu_top_assert lsu_top_assert_inst (
  .i_clk           (i_clk),
  .i_rst_n         (i_rst_n),
  .i_pre_valid     (i_pre_valid),
  .i_req           (i_req),
  .i_sram_rd_valid (sram_rd_valid),
  .i_post_valid    (o_post_valid),
  .i_rsp           (o_rsp)
);

/* tb/lsu_top_tb.sv */
`timescale 1ns/1ps

module lsu_top_tb;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 8;
  localparam int SEED_REQS  = lsu_mem_pkg::MEM_WORDS;
  // upper bound on the directed requests
  localparam int DIR_REQS   = 64;
  localparam int RAND_REQS  = 300;
  localparam int MAX_GAP    = 3;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + SEED_REQS + DIR_REQS +
                                  RAND_REQS * (1 + MAX_GAP) + 100;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_pre_valid;
  lsu_isa_pkg::lsu_req_t i_req;
  logic                  o_post_valid;
  lsu_isa_pkg::lsu_rsp_t o_rsp;

  // model memory, word per index
  logic [31:0]           ref_mem [lsu_mem_pkg::MEM_WORDS];
  // expected responses in issue order
  lsu_isa_pkg::lsu_rsp_t exp_q [$];
  string                 name_q [$];
  lsu_isa_pkg::lsu_rsp_t cmp_exp;
  string                 cmp_name;
  int                    seed;

  lsu_top lsu_top_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pre_valid  (i_pre_valid),
    .i_req        (i_req),
    .o_post_valid (o_post_valid),
    .o_rsp        (o_rsp)
  );

  initial i_clk = 1'b0;
  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // seed value, mixes every address bit
  function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ (a << 7) ^ 32'h1357_9bdf;
  endfunction

  // applies one request to the model, returns what the unit must answer
  function automatic lsu_isa_pkg::lsu_rsp_t ref_lsu(input lsu_isa_pkg::lsu_req_t r);
    lsu_isa_pkg::lsu_rsp_t rsp;
    logic [9:0]  idx;
    logic [1:0]  lo;
    logic [31:0] word;
    logic [7:0]  bt;
    logic [15:0] hw;
    logic        half_op;
    logic        word_op;
    logic        bad;
    rsp     = '0;
    idx     = r.addr[11:2];
    lo      = r.addr[1:0];
    word    = ref_mem[idx];
    bt      = word[8*lo +: 8];
    hw      = word[16*lo[1] +: 16];
    half_op = (r.load_op == lsu_isa_pkg::LD_LH) || (r.load_op == lsu_isa_pkg::LD_LHU) ||
              (r.store_op == lsu_isa_pkg::ST_SH);
    word_op = (r.load_op == lsu_isa_pkg::LD_LW) || (r.store_op == lsu_isa_pkg::ST_SW);
    bad     = (half_op && lo[0]) || (word_op && (lo != 2'b00));
    rsp.misaligned = bad;
    rsp.is_store   = (r.store_op != lsu_isa_pkg::ST_NONE);
    if (!bad) begin
      // read-modify-write of the addressed lanes
      case (r.store_op)
        lsu_isa_pkg::ST_SB: word[8*lo +: 8] = r.wdata[7:0];
        lsu_isa_pkg::ST_SH: word[16*lo[1] +: 16] = r.wdata[15:0];
        lsu_isa_pkg::ST_SW: word = r.wdata;
        default: ;
      endcase
      ref_mem[idx] = word;
      if (!rsp.is_store) begin
        case (r.load_op)
          lsu_isa_pkg::LD_LB:  rsp.data = {{24{bt[7]}}, bt};
          lsu_isa_pkg::LD_LH:  rsp.data = {{16{hw[15]}}, hw};
          lsu_isa_pkg::LD_LW:  rsp.data = word;
          lsu_isa_pkg::LD_LBU: rsp.data = {24'd0, bt};
          lsu_isa_pkg::LD_LHU: rsp.data = {16'd0, hw};
          default:             rsp.data = '0;
        endcase
      end
    end
    return rsp;
  endfunction

  // one request for one cycle, called 2 ns after a rising edge
  task automatic send_req(input string name, input logic [2:0] ld, input logic [2:0] st,
                          input logic [31:0] addr, input logic [31:0] wdata);
    lsu_isa_pkg::lsu_req_t req;
    req.load_op  = ld;
    req.store_op = st;
    req.addr     = addr;
    req.wdata    = wdata;
    i_req        = req;
    i_pre_valid  = 1'b1;
    exp_q.push_back(ref_lsu(req));
    name_q.push_back(name);
    @(posedge i_clk);
    #2;
    i_pre_valid = 1'b0;
    i_req       = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #2;
    end
  endtask

  // sw sweep over the whole 4 KiB
  task automatic seed_memory();
    for (int w = 0; w < SEED_REQS; w++) begin
      send_req("seed_sw", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, w * 4, fill_pattern(w * 4));
    end
  endtask

  // store then two loads back to back
  task automatic test_store_load();
    logic [31:0] a;
    for (int k = 0; k < 2; k++) begin
      a = (k == 0) ? 32'h100 : 32'hffc;
      send_req("sw_lw_store", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, a, 32'hdead_beef + k);
      send_req("sw_lw_load", lsu_isa_pkg::LD_LW, lsu_isa_pkg::ST_NONE, a, 32'd0);
      send_req("sw_lw_again", lsu_isa_pkg::LD_LW, lsu_isa_pkg::ST_NONE, a, 32'd0);
    end
    idle_cycles(2);
  endtask

  // every byte lane, then both halves of the same word
  task automatic test_lane_merge();
    for (int l = 0; l < 4; l++) begin
      send_req("merge_sb", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SB, 32'h200 + l,
               32'hcafe_f010 + l);
    end
    send_req("merge_lw_b", lsu_isa_pkg::LD_LW, lsu_isa_pkg::ST_NONE, 32'h200, 32'd0);
    send_req("merge_sh_lo", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SH, 32'h200, 32'h1234_8765);
    idle_cycles(1);
    send_req("merge_sh_hi", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SH, 32'h202, 32'hffff_0a0b);
    send_req("merge_lw_h", lsu_isa_pkg::LD_LW, lsu_isa_pkg::ST_NONE, 32'h200, 32'd0);
    idle_cycles(2);
  endtask

  // negative bytes and halves in one word, positive in the next
  task automatic test_load_ext();
    logic [31:0] base;
    send_req("ext_fill", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, 32'h300, 32'hf0e0_d0c0);
    send_req("ext_fill", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, 32'h304, 32'h7f3f_1f0f);
    for (int w = 0; w < 2; w++) begin
      base = 32'h300 + 4 * w;
      for (int l = 0; l < 4; l++) begin
        send_req("ext_lb", lsu_isa_pkg::LD_LB, lsu_isa_pkg::ST_NONE, base + l, 32'd0);
        send_req("ext_lbu", lsu_isa_pkg::LD_LBU, lsu_isa_pkg::ST_NONE, base + l, 32'd0);
      end
      for (int h = 0; h < 2; h++) begin
        send_req("ext_lh", lsu_isa_pkg::LD_LH, lsu_isa_pkg::ST_NONE, base + 2 * h, 32'd0);
        send_req("ext_lhu", lsu_isa_pkg::LD_LHU, lsu_isa_pkg::ST_NONE, base + 2 * h, 32'd0);
      end
    end
    idle_cycles(2);
  endtask

  // faulting accesses, then proof the word was left alone
  task automatic test_misaligned();
    send_req("mis_fill", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, 32'h400, 32'h0bad_f00d);
    send_req("mis_lh", lsu_isa_pkg::LD_LH, lsu_isa_pkg::ST_NONE, 32'h401, 32'd0);
    send_req("mis_lhu", lsu_isa_pkg::LD_LHU, lsu_isa_pkg::ST_NONE, 32'h403, 32'd0);
    for (int o = 1; o < 4; o++) begin
      send_req("mis_lw", lsu_isa_pkg::LD_LW, lsu_isa_pkg::ST_NONE, 32'h400 + o, 32'd0);
    end
    send_req("mis_sh", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SH, 32'h401, 32'hffff_ffff);
    send_req("mis_sh", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SH, 32'h403, 32'h5555_5555);
    send_req("mis_sw", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, 32'h402, 32'h1111_2222);
    send_req("mis_sw", lsu_isa_pkg::LD_NONE, lsu_isa_pkg::ST_SW, 32'h401, 32'h3333_4444);
    send_req("mis_unchanged", lsu_isa_pkg::LD_LW, lsu_isa_pkg::ST_NONE, 32'h400, 32'd0);
    idle_cycles(2);
  endtask

  task automatic run_random(input int n);
    int unsigned pick;
    int unsigned gap;
    logic [2:0]  ld;
    logic [2:0]  st;
    logic [31:0] addr;
    logic [31:0] wdata;
    for (int k = 0; k < n; k++) begin
      pick = $unsigned($random(seed)) % 8;
      ld   = lsu_isa_pkg::LD_NONE;
      st   = lsu_isa_pkg::ST_NONE;
      case (pick)
        0: ld = lsu_isa_pkg::LD_LB;
        1: ld = lsu_isa_pkg::LD_LH;
        2: ld = lsu_isa_pkg::LD_LW;
        3: ld = lsu_isa_pkg::LD_LBU;
        4: ld = lsu_isa_pkg::LD_LHU;
        5: st = lsu_isa_pkg::ST_SB;
        6: st = lsu_isa_pkg::ST_SH;
        default: st = lsu_isa_pkg::ST_SW;
      endcase
      addr = $random(seed) & 32'h0000_0fff;
      // three in four forced aligned
      if (($unsigned($random(seed)) % 4) != 0) begin
        if ((ld == lsu_isa_pkg::LD_LW) || (st == lsu_isa_pkg::ST_SW)) begin
          addr[1:0] = 2'b00;
        end else begin
          addr[0] = 1'b0;
        end
      end
      wdata = $random(seed);
      send_req($sformatf("random_%0d", k), ld, st, addr, wdata);
      // 0 or 1 means back to back
      gap = $unsigned($random(seed)) % 4;
      if (gap > 1) begin
        idle_cycles(gap - 1);
      end
    end
  endtask

  // outputs settle after the rising edge, so look at the falling one
  always @(negedge i_clk) begin
    if (lsu_top_inst.lsu_top_assert_inst.err_count != 0) begin
      abort_run("a bound assertion on the unit failed");
    end else if (i_rst_n && o_post_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("response strobe seen with no request outstanding");
      end else begin
        cmp_exp  = exp_q.pop_front();
        cmp_name = name_q.pop_front();
        check_val(cmp_name, {30'd0, cmp_exp}, {30'd0, o_rsp});
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("timeout, the run did not finish in the expected time");
  end

  initial begin
    seed        = 1;
    i_rst_n     = 1'b0;
    i_pre_valid = 1'b0;
    i_req       = '0;
    repeat (RST_CYCLES) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;
    // no strobe before the first request
    repeat (4) begin
      @(negedge i_clk);
      check_val("idle_after_reset", 64'd0, {63'd0, o_post_valid});
    end
    @(posedge i_clk);
    #2;
    seed_memory();
    test_store_load();
    test_lane_merge();
    test_load_ext();
    test_misaligned();
    run_random(RAND_REQS);
    idle_cycles(6);
    if ((exp_q.size() == 0) && (lsu_top_inst.lsu_top_assert_inst.err_count == 0)) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("%0d responses never arrived, %0d assertions failed", exp_q.size(),
               lsu_top_inst.lsu_top_assert_inst.err_count);
      $display("sim failed");
      $fatal(1, "missing responses or failed assertions");
    end
  end

endmodule

/* lsu_top.f */
rtl/lsu_isa_pkg.sv
rtl/lsu_mem_pkg.sv
rtl/lsu_store_align.sv
rtl/lsu_data_sram.sv
rtl/lsu.sv
rtl/lsu_top.sv
tb/lsu_top_assert.sv
tb/lsu_top_tb.sv

/* Bender.yml */
package:
  name: lsu_top

sources:
  - rtl/lsu_isa_pkg.sv
  - rtl/lsu_mem_pkg.sv
  - rtl/lsu_store_align.sv
  - rtl/lsu_data_sram.sv
  - rtl/lsu.sv
  - rtl/lsu_top.sv
  - target: simulation
    files:
      - tb/lsu_top_assert.sv
      - tb/lsu_top_tb.sv
